// File: hw/harness_link_pkg.sv
/*
 * Host link types: word address, data and id widths, the host request
 * and response, and the request as a bank sees it after dispatch.
 */

`default_nettype none

package harness_link_pkg;

  // host address is the bank-local address plus the bank select bits
  localparam int addr_width = harness_mem_cfg_pkg::bank_addr_width
                            + $clog2(harness_mem_cfg_pkg::num_banks);
  localparam int data_width = 32;
  localparam int req_id_width = 4;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [req_id_width-1:0] req_id_t;
  typedef logic [harness_mem_cfg_pkg::bank_addr_width-1:0] bank_addr_t;

  typedef struct packed {
    addr_t   addr;
    data_t   data;
    req_id_t id;
    logic    wr;
  } host_req_s;

  // write responses echo the written word
  typedef struct packed {
    data_t   data;
    req_id_t id;
    logic    wr;
  } host_resp_s;

  typedef struct packed {
    bank_addr_t addr;
    data_t      data;
    req_id_t    id;
    logic       wr;
  } bank_req_s;

endpackage

`default_nettype wire

// File: hw/harness_mem_cfg_pkg.sv
/*
 * Memory-side configuration of the harness: bank count, bank depth and
 * the constants that time the tag and core-reset sequence.
 */

`default_nettype none

package harness_mem_cfg_pkg;

  // number of test-memory banks, must be a power of two
  localparam int num_banks = 4;

  // local word address width inside one bank
  localparam int bank_addr_width = 8;

  // words held by each bank
  localparam int bank_depth = 2 ** bank_addr_width;

  // cycles spent in tag programming before tag done
  localparam int tag_cycles = 8;

  // flops between tag done and core reset release
  localparam int reset_depth = 3;

endpackage

`default_nettype wire

// File: hw/manycore_mem_harness.sv
/*
 * Memory side of the manycore harness. The reset sequencer gates the core,
 * host requests are spread over the test-memory banks by address and the
 * bank responses come back as one stream, three cycles after each request.
 */

`timescale 1ns/100ps
`default_nettype none

module manycore_mem_harness #(
  parameter int num_banks_p = harness_mem_cfg_pkg::num_banks
  , parameter int reset_depth_p = harness_mem_cfg_pkg::reset_depth
) (
  input  logic clk_i
  , input  logic rst_n_i
  , input  logic req_v_i
  , input  harness_link_pkg::host_req_s req_i
  , output logic resp_v_o
  , output harness_link_pkg::host_resp_s resp_o
  , output logic tag_done_o
  , output logic ready_o
);
  import harness_link_pkg::*;

  logic core_rst;
  logic [num_banks_p-1:0] bank_v;
  bank_req_s bank_req;
  logic [num_banks_p-1:0] bank_resp_v;
  host_resp_s [num_banks_p-1:0] bank_resp;

  reset_sequencer #(
    .reset_depth_p(reset_depth_p)
  ) rst_seq (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_done_o(tag_done_o)
    ,.core_rst_o(core_rst)
    ,.ready_o(ready_o)
  );

  request_dispatch #(
    .num_banks_p(num_banks_p)
  ) dispatch (
    .clk_i(clk_i)
    ,.core_rst_i(core_rst)
    ,.req_v_i(req_v_i)
    ,.req_i(req_i)
    ,.bank_v_o(bank_v)
    ,.bank_req_o(bank_req)
  );

  for (genvar i = 0; i < num_banks_p; i++) begin : g_bank
    test_mem_bank test_mem (
      .clk_i(clk_i)
      ,.core_rst_i(core_rst)
      ,.v_i(bank_v[i])
      ,.req_i(bank_req)
      ,.resp_v_o(bank_resp_v[i])
      ,.resp_o(bank_resp[i])
    );
  end

  response_collect #(
    .num_banks_p(num_banks_p)
  ) collect (
    .clk_i(clk_i)
    ,.core_rst_i(core_rst)
    ,.bank_v_i(bank_resp_v)
    ,.bank_resp_i(bank_resp)
    ,.resp_v_o(resp_v_o)
    ,.resp_o(resp_o)
  );

endmodule

`default_nettype wire

// File: hw/request_dispatch.sv
/*
 * Registers each host request and raises the valid of the bank picked by
 * the top address bits, passing the bank-local word address along.
 */

`timescale 1ns/100ps
`default_nettype none

module request_dispatch #(
  parameter int num_banks_p = harness_mem_cfg_pkg::num_banks
) (
  input  logic clk_i
  , input  logic core_rst_i
  , input  logic req_v_i
  , input  harness_link_pkg::host_req_s req_i
  , output logic [num_banks_p-1:0] bank_v_o
  , output harness_link_pkg::bank_req_s bank_req_o
);
  import harness_link_pkg::*;
  import harness_mem_cfg_pkg::*;

  localparam int sel_width_lp = $clog2(num_banks_p);
  localparam int local_width_lp = addr_width - sel_width_lp;

  if (num_banks_p < 2 || local_width_lp > bank_addr_width) begin : g_bad_cfg
    $error("bank count leaves a local address wider than a bank");
  end

  logic [sel_width_lp-1:0] bank_sel;
  logic [num_banks_p-1:0] bank_v_r;
  bank_req_s bank_req_r;

  assign bank_sel = req_i.addr[addr_width-1 -: sel_width_lp];

  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      bank_v_r <= '0;
    end else begin
      bank_v_r <= '0;
      if (req_v_i) begin
        bank_v_r[bank_sel] <= 1'b1;
      end
    end
  end

  // payload is broadcast, only the selected bank looks at it
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      bank_req_r.addr <= bank_addr_t'(req_i.addr[local_width_lp-1:0]);
      bank_req_r.data <= req_i.data;
      bank_req_r.id <= req_i.id;
      bank_req_r.wr <= req_i.wr;
    end
  end

  assign bank_v_o = bank_v_r;
  assign bank_req_o = bank_req_r;

  // host must wait for ready before it strobes a request
  no_req_in_reset_a : assert property (@(posedge clk_i) core_rst_i |-> !req_v_i);

endmodule

`default_nettype wire

// File: hw/reset_sequencer.sv
/*
 * Stands in for tag programming with a counter, then releases the core
 * reset through a flop chain once tag programming is done.
 */

`timescale 1ns/100ps
`default_nettype none

module reset_sequencer #(
  parameter int reset_depth_p = harness_mem_cfg_pkg::reset_depth
) (
  input  logic clk_i
  , input  logic rst_n_i
  , output logic tag_done_o
  , output logic core_rst_o
  , output logic ready_o
);
  import harness_mem_cfg_pkg::*;

  localparam int cnt_width_lp = $clog2(tag_cycles + 1);

  logic [cnt_width_lp-1:0] tag_cnt_r;
  logic tag_done_r;
  logic [reset_depth_p-1:0] rst_chain_r;

  // counter reaches tag_cycles after tag_cycles edges, done one edge later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tag_cnt_r <= '0;
      tag_done_r <= 1'b0;
    end else if (!tag_done_r) begin
      if (tag_cnt_r == cnt_width_lp'(tag_cycles)) begin
        tag_done_r <= 1'b1;
      end else begin
        tag_cnt_r <= tag_cnt_r + 1'b1;
      end
    end
  end

  // core stays in reset until tag done has crossed every stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_chain_r <= '1;
    end else begin
      rst_chain_r[0] <= ~tag_done_r;
      for (int i = 1; i < reset_depth_p; i++) begin
        rst_chain_r[i] <= rst_chain_r[i-1];
      end
    end
  end

  assign tag_done_o = tag_done_r;
  assign core_rst_o = rst_chain_r[reset_depth_p-1];
  assign ready_o = ~rst_chain_r[reset_depth_p-1];

endmodule

`default_nettype wire

// File: hw/response_collect.sv
/*
 * Merges the bank responses into the single registered host response.
 * At most one bank answers in any cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module response_collect #(
  parameter int num_banks_p = harness_mem_cfg_pkg::num_banks
) (
  input  logic clk_i
  , input  logic core_rst_i
  , input  logic [num_banks_p-1:0] bank_v_i
  , input  harness_link_pkg::host_resp_s [num_banks_p-1:0] bank_resp_i
  , output logic resp_v_o
  , output harness_link_pkg::host_resp_s resp_o
);
  import harness_link_pkg::*;

  host_resp_s resp_sel;
  logic resp_v_r;
  host_resp_s resp_r;

  // valids are one-hot, so an or of the masked responses is a mux
  always_comb begin
    resp_sel = '0;
    for (int i = 0; i < num_banks_p; i++) begin
      if (bank_v_i[i]) begin
        resp_sel = resp_sel | bank_resp_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= |bank_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|bank_v_i) begin
      resp_r <= resp_sel;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o = resp_r;

  // dispatch sends one request per cycle and banks share the same latency
  one_bank_resp_a : assert property (
    @(posedge clk_i) disable iff (core_rst_i) $onehot0(bank_v_i));

endmodule

`default_nettype wire

// File: hw/test_mem_bank.sv
/*
 * One bank of test memory. Every request gets a response one cycle later:
 * reads return the stored word, writes store it and echo it back.
 */

`timescale 1ns/100ps
`default_nettype none

module test_mem_bank (
  input  logic clk_i
  , input  logic core_rst_i
  , input  logic v_i
  , input  harness_link_pkg::bank_req_s req_i
  , output logic resp_v_o
  , output harness_link_pkg::host_resp_s resp_o
);
  import harness_link_pkg::*;
  import harness_mem_cfg_pkg::*;

  data_t mem_r [bank_depth];
  logic resp_v_r;
  host_resp_s resp_r;

  always_ff @(posedge clk_i) begin
    if (v_i && req_i.wr) begin
      mem_r[req_i.addr] <= req_i.data;
    end
  end

  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      resp_v_r <= 1'b0;
    end else begin
      resp_v_r <= v_i;
    end
  end

  // old word on a read, new word on a write
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (req_i.wr) begin
        resp_r.data <= req_i.data;
      end else begin
        resp_r.data <= mem_r[req_i.addr];
      end
      resp_r.id <= req_i.id;
      resp_r.wr <= req_i.wr;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o = resp_r;

endmodule

`default_nettype wire

// File: manycore_mem_harness.f
hw/harness_mem_cfg_pkg.sv
hw/harness_link_pkg.sv
hw/reset_sequencer.sv
hw/request_dispatch.sv
hw/test_mem_bank.sv
hw/response_collect.sv
hw/manycore_mem_harness.sv
testbench/tb_manycore_mem_harness.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the harness testbench with Verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1
build_dir=build
log_file=sim.log
if ! verilator --binary --assert --timescale 1ns/100ps --top-module tb_manycore_mem_harness \
    -f manycore_mem_harness.f -Mdir "$build_dir"; then
  echo "verilator build failed"
  exit 1
fi
"./$build_dir/Vtb_manycore_mem_harness" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if grep -q "CHECKS FAILED" "$log_file"; then
  exit 1
fi
exit 0

// File: testbench/tb_manycore_mem_harness.sv
/*
 * Directed testbench for the manycore memory harness. Checks the reset
 * sequence, then runs host reads and writes against a reference memory.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_manycore_mem_harness;
  import harness_link_pkg::*;
  import harness_mem_cfg_pkg::*;

  localparam int half_period_lp = 10;
  localparam int drive_delay_lp = 2;
  localparam int resp_latency_lp = 3;
  localparam int max_cycles_lp = 2000;

  typedef struct packed {
    host_resp_s resp;
    int due;
  } exp_resp_s;

  logic clk;
  logic rst_n;
  logic req_v;
  host_req_s req;
  logic resp_v;
  host_resp_s resp;
  logic tag_done;
  logic ready;
  data_t ref_mem [2 ** addr_width];
  addr_t written_q [$];
  exp_resp_s exp_q [$];
  logic [2**req_id_width-1:0] ids_seen;
  int cycle_cnt;
  int errors;
  int tests_failed;
  int seed;

  manycore_mem_harness #(
    .num_banks_p(num_banks)
    , .reset_depth_p(reset_depth)
  ) dut_i (
    .clk_i(clk)
    , .rst_n_i(rst_n)
    , .req_v_i(req_v)
    , .req_i(req)
    , .resp_v_o(resp_v)
    , .resp_o(resp)
    , .tag_done_o(tag_done)
    , .ready_o(ready)
  );

  always #(half_period_lp) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles_lp) begin
      $display("timeout after %0d cycles, %0d responses pending", cycle_cnt, exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("error at cycle %0d: %s", cycle_cnt, msg);
    errors++;
  endtask

  // sampled mid-cycle, every response is matched against the oldest request
  always @(negedge clk) begin : resp_monitor
    exp_resp_s item;
    if (exp_q.size() != 0 && exp_q[0].due < cycle_cnt) begin
      report_error($sformatf("no response for request with id %0h", exp_q[0].resp.id));
      item = exp_q.pop_front();
    end
    if (resp_v && exp_q.size() == 0) begin
      report_error("response with no request outstanding");
    end else if (resp_v) begin
      item = exp_q.pop_front();
      ids_seen[resp.id] = 1'b1;
      if (resp.data !== item.resp.data) report_mismatch("resp_o.data", resp.data, item.resp.data);
      if (resp.id !== item.resp.id) report_mismatch("resp_o.id", 32'(resp.id), 32'(item.resp.id));
      if (resp.wr !== item.resp.wr) report_mismatch("resp_o.wr", 32'(resp.wr), 32'(item.resp.wr));
      if (cycle_cnt != item.due) report_mismatch("resp_v_o cycle", cycle_cnt, item.due);
    end
  end

  function automatic addr_t make_addr(input int bank, input int offset);
    return addr_t'((bank << bank_addr_width) + offset);
  endfunction

  // one request in the current cycle, expected response queued
  task automatic send_req(input addr_t address, input data_t word, input req_id_t tag,
                          input logic write);
    exp_resp_s item;
    req_v = 1'b1;
    req = '{addr: address, data: word, id: tag, wr: write};
    if (write) begin
      ref_mem[address] = word;
      written_q.push_back(address);
    end
    item.resp = '{data: ref_mem[address], id: tag, wr: write};
    item.due = cycle_cnt + resp_latency_lp;
    exp_q.push_back(item);
    @(posedge clk);
    #(drive_delay_lp);
    req_v = 1'b0;
  endtask

  task automatic wait_responses;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    #(drive_delay_lp);
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic check_reset_sequence;
    int start_errors;
    int edges;
    start_errors = errors;
    repeat (4) begin
      @(posedge clk);
      #(drive_delay_lp);
      if (tag_done !== 1'b0) report_mismatch("tag_done_o", 32'(tag_done), 32'h0);
      if (ready !== 1'b0) report_mismatch("ready_o", 32'(ready), 32'h0);
    end
    rst_n = 1'b1;
    edges = 0;
    while (tag_done !== 1'b1 && edges <= 2 * tag_cycles) begin
      @(posedge clk);
      #(drive_delay_lp);
      edges++;
      if (ready !== 1'b0) report_mismatch("ready_o", 32'(ready), 32'h0);
    end
    // first edge with reset released counts as cycle zero
    if (edges - 1 != tag_cycles) report_mismatch("tag_done_o delay", 32'(edges - 1), 32'(tag_cycles));
    edges = 0;
    while (ready !== 1'b1 && edges <= 2 * reset_depth) begin
      @(posedge clk);
      #(drive_delay_lp);
      edges++;
    end
    if (edges != reset_depth) report_mismatch("ready_o delay", 32'(edges), 32'(reset_depth));
    report_test("reset sequence", start_errors);
  endtask

  task automatic write_then_read;
    int start_errors;
    start_errors = errors;
    send_req(make_addr(1, 42), $random(seed), 4'h3, 1'b1);
    @(posedge clk);
    #(drive_delay_lp);
    send_req(make_addr(1, 42), '0, 4'h9, 1'b0);
    wait_responses();
    report_test("write then read", start_errors);
  endtask

  task automatic bank_isolation;
    int start_errors;
    start_errors = errors;
    // top byte of each word is its bank number, so all words differ
    for (int b = 0; b < num_banks; b++) begin
      send_req(make_addr(b, 85), {8'(b), 24'($random(seed))}, req_id_t'(b), 1'b1);
    end
    for (int b = 0; b < num_banks; b++) begin
      send_req(make_addr(b, 85), '0, req_id_t'(b + 8), 1'b0);
    end
    wait_responses();
    report_test("bank isolation", start_errors);
  endtask

  task automatic back_to_back_stream;
    int start_errors;
    int idx;
    logic [31:0] r;
    start_errors = errors;
    for (int n = 0; n < 64; n++) begin
      r = $random(seed);
      if (r[0] || written_q.size() == 0) begin
        send_req(addr_t'(r[31:16]), $random(seed), req_id_t'(n), 1'b1);
      end else begin
        idx = int'(r[30:8]) % written_q.size();
        send_req(written_q[idx], '0, req_id_t'(n), 1'b0);
      end
    end
    wait_responses();
    report_test("back-to-back stream", start_errors);
  endtask

  task automatic id_echo;
    int start_errors;
    start_errors = errors;
    ids_seen = '0;
    for (int i = 0; i < 2 ** req_id_width; i++) begin
      send_req(make_addr(i % num_banks, 192 + i), $random(seed), req_id_t'(i), 1'b1);
    end
    for (int i = 0; i < 2 ** req_id_width; i++) begin
      send_req(make_addr(i % num_banks, 192 + i), '0, req_id_t'(15 - i), 1'b0);
    end
    wait_responses();
    if (ids_seen !== '1) report_mismatch("ids seen", 32'(ids_seen), 32'({(2**req_id_width){1'b1}}));
    report_test("id echo", start_errors);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    req_v = 1'b0;
    req = '0;
    ids_seen = '0;
    cycle_cnt = 0;
    errors = 0;
    tests_failed = 0;
    seed = 36;
    check_reset_sequence();
    write_then_read();
    bank_isolation();
    back_to_back_stream();
    id_echo();
    $display("tests run 5, tests failed %0d, check errors %0d", tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
